// ==== compile.f ====
+incdir+src
src/bp_pkg.sv
src/bp_counter_table.sv
src/bp_chooser.sv
src/bp_update_writer.sv
src/bp_wb_ctrl.sv
src/bp_top.sv
dv/bp_tb.sv

// ==== dv/bp_tb.sv ====
`timescale 1ns/1ns
`include "bp_config.svh"

module bp_tb;

  localparam int max_cycles = 5000;  // About 450 transfers of 3 cycles, plus resets.

  logic                   clk;
  logic                   rst_n;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  logic [1:0]             wb_adr;
  logic [`BP_DATA_W-1:0]  wb_dat_w;
  logic [`BP_DATA_W-1:0]  wb_dat_r;
  logic                   wb_ack;
  int                     errors;
  int                     test_errors;
  int                     tests_run;
  int                     cycles;
  logic [31:0]            rng;
  // Reference model state.
  logic [`BP_INDEX_W-1:0] lookup;
  logic [`BP_HIST_W-1:0]  hist;
  logic                   m_sp  [`BP_ENTRIES];
  logic [1:0]             m_lhp [`BP_ENTRIES];
  logic [1:0]             m_ghp [`BP_ENTRIES];
  int                     s_sp  [`BP_ENTRIES];
  int                     s_lhp [`BP_ENTRIES];
  int                     s_ghp [`BP_ENTRIES];

  bp_top bp_top_i (
    .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= max_cycles)
    begin
      $display("Timeout: tests did not finish within %0d cycles", max_cycles);
      $display("test failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [1:0] saturate(input logic [1:0] c, input logic up);
    if (up)
      return (c == 2'd3) ? c : c + 2'd1;
    return (c == 2'd0) ? c : c - 2'd1;
  endfunction

  // Highest score wins, ties go SP then LHP.
  function automatic logic [2:0] model_pred(input logic [`BP_INDEX_W-1:0] i);
    if (s_sp[i] >= s_lhp[i] && s_sp[i] >= s_ghp[i])
      return {2'd0, m_sp[i]};
    if (s_lhp[i] >= s_ghp[i])
      return {2'd1, m_lhp[i][1]};
    return {2'd2, m_ghp[i ^ hist][1]};
  endfunction

  function automatic logic [15:0] stats_word(input logic [`BP_INDEX_W-1:0] i);
    return {1'b0, 5'(s_sp[i]), 5'(s_lhp[i]), 5'(s_ghp[i])};
  endfunction

  function automatic void model_resolve(input logic [`BP_INDEX_W-1:0] i, input logic t);
    logic [`BP_INDEX_W-1:0] g;
    int n_sp;
    int n_lhp;
    int n_ghp;
    g = i ^ hist;
    n_sp = s_sp[i] + ((m_sp[i] == t) ? 1 : -1);
    n_lhp = s_lhp[i] + ((m_lhp[i][1] == t) ? 1 : -1);
    n_ghp = s_ghp[i] + ((m_ghp[g][1] == t) ? 1 : -1);
    if (n_sp > 15 || n_sp < -16 || n_lhp > 15 || n_lhp < -16 ||
        n_ghp > 15 || n_ghp < -16)
    begin
      n_sp = 0;
      n_lhp = 0;
      n_ghp = 0;
    end
    s_sp[i] = n_sp;
    s_lhp[i] = n_lhp;
    s_ghp[i] = n_ghp;
    m_sp[i] = t;
    m_lhp[i] = saturate(m_lhp[i], t);
    m_ghp[g] = saturate(m_ghp[g], t);
    hist = {hist[`BP_HIST_W-2:0], t};
  endfunction

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < `BP_ENTRIES; i++)
    begin
      m_sp[i] = 1'b0;
      m_lhp[i] = 2'd0;
      m_ghp[i] = 2'd0;
      s_sp[i] = 0;
      s_lhp[i] = 0;
      s_ghp[i] = 0;
    end
    hist = '0;
    lookup = '0;
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [15:0] dat);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we <= 1'b1;
    wb_adr <= adr;
    wb_dat_w <= dat;
    do @(negedge clk); while (!wb_ack);
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we <= 1'b0;
  endtask

  task automatic wb_read(input logic [1:0] adr, output logic [15:0] dat);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we <= 1'b0;
    wb_adr <= adr;
    do @(negedge clk); while (!wb_ack);
    dat = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic report_mismatch(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
    $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    test_errors++;
  endtask

  task automatic set_lookup(input logic [`BP_INDEX_W-1:0] i);
    wb_write(bp_pkg::REG_LOOKUP, {13'd0, i});
    lookup = i;
  endtask

  task automatic resolve(input logic [`BP_INDEX_W-1:0] i, input logic t);
    wb_write(bp_pkg::REG_RESOLVE, {12'd0, t, i});
    model_resolve(i, t);
  endtask

  task automatic check_pred();
    logic [15:0] d;
    logic [15:0] e;
    wb_read(bp_pkg::REG_PRED, d);
    e = {13'd0, model_pred(lookup)};
    if (d !== e)
      report_mismatch("wb_dat_r (PRED)", d, e);
  endtask

  task automatic check_stats();
    logic [15:0] d;
    logic [15:0] e;
    wb_read(bp_pkg::REG_STATS, d);
    e = stats_word(lookup);
    if (d !== e)
      report_mismatch("wb_dat_r (STATS)", d, e);
  endtask

  task automatic finish_test(input string name);
    $display("%s done, %0d errors", name, test_errors);
    errors += test_errors;
    test_errors = 0;
    tests_run++;
  endtask

  task automatic after_reset();
    logic [15:0] d;
    wb_read(bp_pkg::REG_PRED, d);
    if (d !== 16'h0000)
      report_mismatch("wb_dat_r (PRED)", d, 16'h0000);
    wb_read(bp_pkg::REG_STATS, d);
    if (d !== 16'h0000)
      report_mismatch("wb_dat_r (STATS)", d, 16'h0000);
    finish_test("after_reset");
  endtask

  task automatic lhp_saturation();
    set_lookup(3'd1);
    repeat (5)
    begin
      resolve(3'd1, 1'b1);
      check_pred();
      check_stats();
    end
    finish_test("lhp_saturation");
  endtask

  // Pattern TTTTN: LHP misses once per period, SP twice.
  task automatic chooser_switch();
    logic [15:0] d;
    apply_reset();
    set_lookup(3'd0);
    for (int p = 0; p < 3; p++)
    begin
      for (int k = 0; k < 5; k++)
      begin
        resolve(3'd0, k < 4);
        check_pred();
        check_stats();
      end
      wb_read(bp_pkg::REG_PRED, d);
      if (p == 1 && d !== 16'h0000)
        report_mismatch("wb_dat_r (PRED, SP on tie)", d, 16'h0000);
      if (p == 2 && d !== 16'h0003)
        report_mismatch("wb_dat_r (PRED, LHP chosen)", d, 16'h0003);
    end
    finish_test("chooser_switch");
  endtask

  task automatic score_overflow();
    logic [15:0] d;
    set_lookup(3'd5);
    for (int n = 0; n < 40; n++)
    begin
      if (s_sp[5] == 15 || s_lhp[5] == 15 || s_ghp[5] == 15)
        break;
      resolve(3'd5, 1'b0);
      check_pred();
      check_stats();
    end
    // SP is right on every not-taken resolve of a fresh index.
    wb_read(bp_pkg::REG_STATS, d);
    if (d[14:10] !== 5'd15)
      report_mismatch("wb_dat_r (STATS sp score)", {11'd0, d[14:10]}, 16'd15);
    resolve(3'd5, 1'b0);
    wb_read(bp_pkg::REG_STATS, d);
    if (d !== 16'h0000)
      report_mismatch("wb_dat_r (STATS after overflow)", d, 16'h0000);
    finish_test("score_overflow");
  endtask

  // Index 6 follows the last outcome of index 2, which only GHP can see.
  task automatic history_indexing();
    logic [15:0] d;
    apply_reset();
    repeat (4)
    begin
      resolve(3'd2, 1'b1);
      resolve(3'd6, 1'b1);
      resolve(3'd2, 1'b0);
      resolve(3'd6, 1'b0);
    end
    resolve(3'd1, 1'b0);
    resolve(3'd1, 1'b0);
    resolve(3'd1, 1'b1);
    set_lookup(3'd6);
    wb_read(bp_pkg::REG_PRED, d);
    if (d !== 16'h0005)
      report_mismatch("wb_dat_r (PRED, history 001)", d, 16'h0005);
    check_pred();
    check_stats();
    resolve(3'd2, 1'b1);
    resolve(3'd2, 1'b1);
    resolve(3'd2, 1'b0);
    wb_read(bp_pkg::REG_PRED, d);
    if (d !== 16'h0004)
      report_mismatch("wb_dat_r (PRED, history 110)", d, 16'h0004);
    check_pred();
    finish_test("history_indexing");
  endtask

  task automatic random_traffic();
    rng = 32'd75;
    for (int n = 0; n < 300; n++)
    begin
      rng = xorshift32(rng);
      case (rng[1:0])
        2'd0: set_lookup(rng[4:2]);
        2'd1: check_pred();
        2'd2: resolve(rng[4:2], rng[5]);
        default: check_stats();
      endcase
    end
    finish_test("random_traffic");
  endtask

  initial
  begin
    rst_n = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = 2'd0;
    wb_dat_w = '0;
    apply_reset();
    after_reset();
    lhp_saturation();
    chooser_switch();
    score_overflow();
    history_indexing();
    random_traffic();
    $display("%0d tests run, %0d errors", tests_run, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output.
verilator --binary --timing --top-module bp_tb -o bp_sim -f compile.f &&
./obj_dir/bp_sim | tee /dev/stderr | grep -q "test passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }

// ==== src/bp_chooser.sv ====
`timescale 1ns/1ns
`include "bp_config.svh"

module bp_chooser
(
  input  logic                 sp_dir,
  input  logic [`BP_DIR_W-1:0] lhp_dir,
  input  logic [`BP_DIR_W-1:0] ghp_dir,
  input  bp_pkg::score_set_t   scores,
  output bp_pkg::predictor_e   choice,
  output logic                 taken
);

  logic signed [`BP_SCORE_W-1:0] sp_score;
  logic signed [`BP_SCORE_W-1:0] lhp_score;
  logic signed [`BP_SCORE_W-1:0] ghp_score;
  logic                          sp_wins;
  logic                          lhp_wins;

  assign sp_score  = scores.sp;
  assign lhp_score = scores.lhp;
  assign ghp_score = scores.ghp;

  // Ties favour SP, then LHP.
  assign sp_wins  = (sp_score >= lhp_score) && (sp_score >= ghp_score);
  assign lhp_wins = lhp_score >= ghp_score;

  always_comb
  begin
    if (sp_wins)
    begin
      choice = bp_pkg::PRED_SP;
      taken  = sp_dir;
    end
    else if (lhp_wins)
    begin
      choice = bp_pkg::PRED_LHP;
      taken  = lhp_dir[`BP_DIR_W-1];  // Counter MSB.
    end
    else
    begin
      choice = bp_pkg::PRED_GHP;
      taken  = ghp_dir[`BP_DIR_W-1];
    end
  end

endmodule

// ==== src/bp_config.svh ====
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// Predictor table geometry.
`define BP_ENTRIES 8
`define BP_INDEX_W 3
`define BP_DIR_W   2
`define BP_SCORE_W 5
`define BP_DATA_W  16
`define BP_HIST_W  3

`endif

// ==== src/bp_counter_table.sv ====
`timescale 1ns/1ns
`include "bp_config.svh"

module bp_counter_table #(
  parameter type entry_t = logic
)
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`BP_INDEX_W-1:0] rd_index,
  input  logic                   we,
  input  logic [`BP_INDEX_W-1:0] wr_index,
  input  entry_t                 wdata,
  output entry_t                 rdata
);

  entry_t mem [`BP_ENTRIES];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `BP_ENTRIES; i++)
      begin
        mem[i] <= '0;
      end
    end
    else if (we)
    begin
      mem[wr_index] <= wdata;
    end
  end

  // Read is combinational.
  assign rdata = mem[rd_index];

endmodule

// ==== src/bp_pkg.sv ====
`include "bp_config.svh"

package bp_pkg;

  typedef enum logic [1:0] {
    PRED_SP  = 2'd0,
    PRED_LHP = 2'd1,
    PRED_GHP = 2'd2
  } predictor_e;

  typedef enum logic [1:0] {
    REG_LOOKUP  = 2'd0,
    REG_PRED    = 2'd1,
    REG_RESOLVE = 2'd2,
    REG_STATS   = 2'd3
  } wb_reg_e;

  // Accuracy scores, SP in the top bits.
  typedef struct packed {
    logic signed [`BP_SCORE_W-1:0] sp;
    logic signed [`BP_SCORE_W-1:0] lhp;
    logic signed [`BP_SCORE_W-1:0] ghp;
  } score_set_t;

endpackage

// ==== src/bp_top.sv ====
`timescale 1ns/1ns
`include "bp_config.svh"

module bp_top
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [1:0]            wb_adr,
  input  logic [`BP_DATA_W-1:0] wb_dat_w,
  output logic [`BP_DATA_W-1:0] wb_dat_r,
  output logic                  wb_ack
);

  logic [`BP_INDEX_W-1:0] rd_index;
  logic [`BP_INDEX_W-1:0] ghp_index;
  logic                   resolve_taken;
  logic                   update;
  logic                   sp_dir;
  logic [`BP_DIR_W-1:0]   lhp_dir;
  logic [`BP_DIR_W-1:0]   ghp_dir;
  bp_pkg::score_set_t     scores;
  logic                   new_sp_dir;
  logic [`BP_DIR_W-1:0]   new_lhp_dir;
  logic [`BP_DIR_W-1:0]   new_ghp_dir;
  bp_pkg::score_set_t     new_scores;
  bp_pkg::predictor_e     pred_choice;
  logic                   pred_taken;

  bp_wb_ctrl u_ctrl (
    .clk(clk), .rst_n(rst_n),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
    .pred_choice(pred_choice), .pred_taken(pred_taken), .scores(scores),
    .wb_ack(wb_ack), .wb_dat_r(wb_dat_r), .rd_index(rd_index), .ghp_index(ghp_index),
    .resolve_taken(resolve_taken), .update(update)
  );

  bp_counter_table #(.entry_t(logic)) u_sp_table (
    .clk(clk), .rst_n(rst_n), .rd_index(rd_index), .we(update), .wr_index(rd_index),
    .wdata(new_sp_dir), .rdata(sp_dir)
  );

  bp_counter_table #(.entry_t(logic [`BP_DIR_W-1:0])) u_lhp_table (
    .clk(clk), .rst_n(rst_n), .rd_index(rd_index), .we(update), .wr_index(rd_index),
    .wdata(new_lhp_dir), .rdata(lhp_dir)
  );

  // Global table sits behind the history hash.
  bp_counter_table #(.entry_t(logic [`BP_DIR_W-1:0])) u_ghp_table (
    .clk(clk), .rst_n(rst_n), .rd_index(ghp_index), .we(update), .wr_index(ghp_index),
    .wdata(new_ghp_dir), .rdata(ghp_dir)
  );

  bp_counter_table #(.entry_t(bp_pkg::score_set_t)) u_score_table (
    .clk(clk), .rst_n(rst_n), .rd_index(rd_index), .we(update), .wr_index(rd_index),
    .wdata(new_scores), .rdata(scores)
  );

  bp_chooser u_chooser (
    .sp_dir(sp_dir), .lhp_dir(lhp_dir), .ghp_dir(ghp_dir), .scores(scores),
    .choice(pred_choice), .taken(pred_taken)
  );

  bp_update_writer u_writer (
    .taken(resolve_taken), .sp_dir(sp_dir), .lhp_dir(lhp_dir), .ghp_dir(ghp_dir),
    .scores(scores), .new_sp_dir(new_sp_dir), .new_lhp_dir(new_lhp_dir),
    .new_ghp_dir(new_ghp_dir), .new_scores(new_scores)
  );

endmodule

// ==== src/bp_update_writer.sv ====
`timescale 1ns/1ns
`include "bp_config.svh"

module bp_update_writer
(
  input  logic                 taken,
  input  logic                 sp_dir,
  input  logic [`BP_DIR_W-1:0] lhp_dir,
  input  logic [`BP_DIR_W-1:0] ghp_dir,
  input  bp_pkg::score_set_t   scores,
  output logic                 new_sp_dir,
  output logic [`BP_DIR_W-1:0] new_lhp_dir,
  output logic [`BP_DIR_W-1:0] new_ghp_dir,
  output bp_pkg::score_set_t   new_scores
);

  localparam int score_w = `BP_SCORE_W;
  localparam int dir_w   = `BP_DIR_W;
  localparam logic signed [score_w:0] score_one = 1;

  logic                     sp_ok;
  logic                     lhp_ok;
  logic                     ghp_ok;
  logic signed [score_w:0]  sp_sum;
  logic signed [score_w:0]  lhp_sum;
  logic signed [score_w:0]  ghp_sum;
  logic [2:0]               ovf;

  // Two-bit saturating counter step.
  function automatic logic [dir_w-1:0] step_count(
    input logic [dir_w-1:0] cnt,
    input logic             up
  );
    logic [dir_w-1:0] result;
    if (up)
      result = (cnt == {dir_w{1'b1}}) ? cnt : cnt + 1'b1;
    else
      result = (cnt == '0) ? cnt : cnt - 1'b1;
    return result;
  endfunction

  // One bit wider so overflow shows in the top two bits.
  function automatic logic signed [score_w:0] step_score(
    input logic signed [score_w-1:0] score,
    input logic                      correct
  );
    logic signed [score_w:0] wide;
    wide = {score[score_w-1], score};
    return correct ? wide + score_one : wide - score_one;
  endfunction

  assign sp_ok  = sp_dir == taken;
  assign lhp_ok = lhp_dir[dir_w-1] == taken;
  assign ghp_ok = ghp_dir[dir_w-1] == taken;

  assign new_sp_dir  = taken;  // SP just remembers the last outcome.
  assign new_lhp_dir = step_count(lhp_dir, taken);
  assign new_ghp_dir = step_count(ghp_dir, taken);

  assign sp_sum  = step_score(scores.sp, sp_ok);
  assign lhp_sum = step_score(scores.lhp, lhp_ok);
  assign ghp_sum = step_score(scores.ghp, ghp_ok);

  assign ovf[2] = sp_sum[score_w] != sp_sum[score_w-1];
  assign ovf[1] = lhp_sum[score_w] != lhp_sum[score_w-1];
  assign ovf[0] = ghp_sum[score_w] != ghp_sum[score_w-1];

  always_comb
  begin
    if (|ovf)
    begin
      new_scores = '0;  // Any overflow restarts the whole set.
    end
    else
    begin
      new_scores.sp  = sp_sum[score_w-1:0];
      new_scores.lhp = lhp_sum[score_w-1:0];
      new_scores.ghp = ghp_sum[score_w-1:0];
    end
  end

endmodule

// ==== src/bp_wb_ctrl.sv ====
`timescale 1ns/1ns
`include "bp_config.svh"

module bp_wb_ctrl
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  logic [1:0]             wb_adr,
  input  logic [`BP_DATA_W-1:0]  wb_dat_w,
  input  bp_pkg::predictor_e     pred_choice,
  input  logic                   pred_taken,
  input  bp_pkg::score_set_t     scores,
  output logic                   wb_ack,
  output logic [`BP_DATA_W-1:0]  wb_dat_r,
  output logic [`BP_INDEX_W-1:0] rd_index,
  output logic [`BP_INDEX_W-1:0] ghp_index,
  output logic                   resolve_taken,
  output logic                   update
);

  bp_pkg::wb_reg_e        reg_sel;
  logic                   req;
  logic [`BP_INDEX_W-1:0] lookup_index;
  logic [`BP_HIST_W-1:0]  history;
  logic [`BP_DATA_W-1:0]  rd_data;

  assign reg_sel = bp_pkg::wb_reg_e'(wb_adr);

  // New request, not yet acknowledged.
  assign req = wb_cyc && wb_stb && !wb_ack;

  // Commit cycle of a RESOLVE write.
  assign update        = req && wb_we && (reg_sel == bp_pkg::REG_RESOLVE);
  assign resolve_taken = wb_dat_w[3];

  assign rd_index  = update ? wb_dat_w[`BP_INDEX_W-1:0] : lookup_index;
  assign ghp_index = rd_index ^ history;  // Gshare style hash.

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wb_ack       <= 1'b0;
      lookup_index <= '0;
      history      <= '0;
    end
    else
    begin
      wb_ack <= req;
      if (req && wb_we && (reg_sel == bp_pkg::REG_LOOKUP))
      begin
        lookup_index <= wb_dat_w[`BP_INDEX_W-1:0];
      end
      if (update)
      begin
        history <= {history[`BP_HIST_W-2:0], resolve_taken};  // Newest in LSB.
      end
    end
  end

  always_comb
  begin
    case (reg_sel)
      bp_pkg::REG_LOOKUP:
        rd_data = {{(`BP_DATA_W-`BP_INDEX_W){1'b0}}, lookup_index};
      bp_pkg::REG_PRED:
        rd_data = {{(`BP_DATA_W-3){1'b0}}, pred_choice, pred_taken};
      bp_pkg::REG_RESOLVE:
        rd_data = {{(`BP_DATA_W-`BP_HIST_W){1'b0}}, history};
      default:
        rd_data = {{(`BP_DATA_W-$bits(bp_pkg::score_set_t)){1'b0}}, scores};
    endcase
  end

  // Read data lands with ack.
  always_ff @(posedge clk)
  begin
    if (req && !wb_we)
    begin
      wb_dat_r <= rd_data;
    end
  end

endmodule
